/* Makefile */
# Verilator build and run of the execute stage testbench.

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module tb_ex_stage
	@out="$$(./obj_dir/Vtb_ex_stage)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

/* all.f */
rv_isa_pkg.sv
pipe_pkg.sv
mem_req_if.sv
ex_alu.sv
lsu_apb.sv
ex_mem_reg.sv
ex_stage.sv
tb_clk_gen.sv
tb_apb_mem.sv
tb_ex_stage.sv

/* ex_alu.sv */
/*
 * Execute ALU.
 * RV64I integer operations with 32-bit word variants, address
 * generation and store lane alignment for the load-store unit.
 */
`timescale 1ns/1ps

module ex_alu
	import rv_isa_pkg::*;
	import pipe_pkg::*;
(
	input  alu_op_e         alu_op_i,
	input  logic            word_op_i,
	input  logic [XLEN-1:0] op_a_i,
	input  logic [XLEN-1:0] op_b_i,
	input  logic [XLEN-1:0] rs2_data_i,
	input  load_code_e      load_code_i,
	input  store_code_e     store_code_i,
	output logic [XLEN-1:0] result_o,
	mem_req_if.drv          req
);

	logic [XLEN-1:0]    res64;
	logic [31:0]        res32;
	logic [XLEN-1:0]    addr_sum;
	logic [2:0]         off;
	data_lane_u         lane;
	logic [PSTRB_W-1:0] strb;
	logic               half_acc;
	logic               word_acc;
	logic               dword_acc;
	logic               misaligned;

	// ------------------------------
	// integer operations
	// ------------------------------
	always_comb begin
		case (alu_op_i)
			ALU_ADD:  res64 = op_a_i + op_b_i;
			ALU_SUB:  res64 = op_a_i - op_b_i;
			ALU_SLL:  res64 = op_a_i << op_b_i[5:0];
			ALU_SLT:  res64 = {63'd0, $signed(op_a_i) < $signed(op_b_i)};
			ALU_SLTU: res64 = {63'd0, op_a_i < op_b_i};
			ALU_XOR:  res64 = op_a_i ^ op_b_i;
			ALU_SRL:  res64 = op_a_i >> op_b_i[5:0];
			ALU_SRA:  res64 = $signed(op_a_i) >>> op_b_i[5:0];
			ALU_OR:   res64 = op_a_i | op_b_i;
			ALU_AND:  res64 = op_a_i & op_b_i;
			default:  res64 = '0;
		endcase
	end

	// word variants, 5-bit shift amount.
	always_comb begin
		case (alu_op_i)
			ALU_ADD:  res32 = op_a_i[31:0] + op_b_i[31:0];
			ALU_SUB:  res32 = op_a_i[31:0] - op_b_i[31:0];
			ALU_SLL:  res32 = op_a_i[31:0] << op_b_i[4:0];
			ALU_SLT:  res32 = {31'd0, $signed(op_a_i[31:0]) < $signed(op_b_i[31:0])};
			ALU_SLTU: res32 = {31'd0, op_a_i[31:0] < op_b_i[31:0]};
			ALU_XOR:  res32 = op_a_i[31:0] ^ op_b_i[31:0];
			ALU_SRL:  res32 = op_a_i[31:0] >> op_b_i[4:0];
			ALU_SRA:  res32 = $signed(op_a_i[31:0]) >>> op_b_i[4:0];
			ALU_OR:   res32 = op_a_i[31:0] | op_b_i[31:0];
			ALU_AND:  res32 = op_a_i[31:0] & op_b_i[31:0];
			default:  res32 = '0;
		endcase
	end

	assign result_o = word_op_i ? {{32{res32[31]}}, res32} : res64;

	// ------------------------------
	// address and store lanes
	// ------------------------------
	assign addr_sum = op_a_i + op_b_i;
	assign off      = addr_sum[2:0];

	always_comb begin
		lane = '0;
		strb = '0;
		case (store_code_i)
			ST_SB: begin
				lane.b[off] = rs2_data_i[7:0];
				strb        = 8'h01 << off;
			end
			ST_SH: begin
				lane.h[off[2:1]] = rs2_data_i[15:0];
				strb             = 8'h03 << off;
			end
			ST_SW: begin
				lane.w[off[2]] = rs2_data_i[31:0];
				strb           = 8'h0f << off;
			end
			ST_SD: begin
				lane.dw = rs2_data_i;
				strb    = 8'hff;
			end
			default: begin
				lane = '0; // loads drive no strobes.
			end
		endcase
	end

	assign req.valid = (load_code_i != LD_NONE) || (store_code_i != ST_NONE);
	assign req.write = (store_code_i != ST_NONE);
	assign req.addr  = addr_sum[PADDR_W-1:0];
	assign req.wdata = lane;
	assign req.strb  = strb;

	// natural alignment only.
	assign half_acc  = (store_code_i == ST_SH) || (load_code_i inside {LD_LH, LD_LHU});
	assign word_acc  = (store_code_i == ST_SW) || (load_code_i inside {LD_LW, LD_LWU});
	assign dword_acc = (store_code_i == ST_SD) || (load_code_i == LD_LD);
	assign misaligned = (half_acc && off[0]) ||
		(word_acc && (off[1:0] != 2'b00)) ||
		(dword_acc && (off != 3'b000));

	always_comb begin
		if (req.valid) begin
			assert (!misaligned)
				else $error("ex_alu: misaligned access at %h", addr_sum);
		end
	end

endmodule

/* ex_mem_reg.sv */
/*
 * EX/MEM pipeline register.
 * Captures an ALU result or extended load data for write-back,
 * and holds while the stage is frozen.
 */
`timescale 1ns/1ps

module ex_mem_reg
	import rv_isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  freeze_i,
	input  logic                  alu_valid_i,
	input  logic [XLEN-1:0]       alu_result_i,
	input  logic                  mem_done_i,
	input  data_lane_u            mem_rdata_i,
	input  logic [2:0]            addr_lo_i,
	input  load_code_e            load_code_i,
	input  logic [REG_ADDR_W-1:0] rd_addr_i,
	input  logic                  reg_wr_en_i,
	output logic                  wb_valid_o,
	output logic                  reg_wr_en_o,
	output logic [REG_ADDR_W-1:0] addr_reg_wr_o,
	output logic [XLEN-1:0]       data_reg_wr_o
);

	logic [7:0]      byte_sel;
	logic [15:0]     half_sel;
	logic [31:0]     word_sel;
	logic [XLEN-1:0] load_val;
	logic            capture;

	// ------------------------------
	// load extraction
	// ------------------------------
	assign byte_sel = mem_rdata_i.b[addr_lo_i];
	assign half_sel = mem_rdata_i.h[addr_lo_i[2:1]];
	assign word_sel = mem_rdata_i.w[addr_lo_i[2]];

	always_comb begin
		case (load_code_i)
			LD_LB:   load_val = {{56{byte_sel[7]}}, byte_sel};
			LD_LH:   load_val = {{48{half_sel[15]}}, half_sel};
			LD_LW:   load_val = {{32{word_sel[31]}}, word_sel};
			LD_LD:   load_val = mem_rdata_i.dw;
			LD_LBU:  load_val = {56'd0, byte_sel};
			LD_LHU:  load_val = {48'd0, half_sel};
			LD_LWU:  load_val = {32'd0, word_sel};
			default: load_val = '0; // stores write nothing back.
		endcase
	end

	assign capture = alu_valid_i || mem_done_i;

	// ------------------------------
	// register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wb_valid_o  <= 1'b0;
			reg_wr_en_o <= 1'b0;
		end else if (!freeze_i) begin
			wb_valid_o <= capture; // one cycle per result.
			if (alu_valid_i) begin
				reg_wr_en_o <= reg_wr_en_i;
			end else if (mem_done_i) begin
				reg_wr_en_o <= reg_wr_en_i && (load_code_i != LD_NONE);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze_i && capture) begin
			addr_reg_wr_o <= rd_addr_i;
			data_reg_wr_o <= mem_done_i ? load_val : alu_result_i;
		end
	end

endmodule

/* ex_stage.sv */
/*
 * Execute stage of the RV64I pipeline.
 * ALU, APB load-store unit and EX/MEM register, with hold and
 * a valid/ready handshake towards decode.
 */
`timescale 1ns/1ps

module ex_stage
	import rv_isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  hold_code_e            hold_code_i,
	input  logic                  valid_i,
	output logic                  ready_o,
	input  alu_op_e               alu_op_i,
	input  logic                  word_op_i,
	input  logic [XLEN-1:0]       op_a_i,
	input  logic [XLEN-1:0]       op_b_i,
	input  logic [XLEN-1:0]       rs2_data_i,
	input  load_code_e            load_code_i,
	input  store_code_e           store_code_i,
	input  logic [REG_ADDR_W-1:0] rd_addr_i,
	input  logic                  reg_wr_en_i,
	output logic                  wb_valid_o,
	output logic                  reg_wr_en_o,
	output logic [REG_ADDR_W-1:0] addr_reg_wr_o,
	output logic [XLEN-1:0]       data_reg_wr_o,
	output logic                  psel_o,
	output logic                  penable_o,
	output logic                  pwrite_o,
	output logic [PADDR_W-1:0]    paddr_o,
	output logic [PDATA_W-1:0]    pwdata_o,
	output logic [PSTRB_W-1:0]    pstrb_o,
	input  logic [PDATA_W-1:0]    prdata_i,
	input  logic                  pready_i
);

	mem_req_if mem_req ();

	logic                  freeze;
	logic                  accept;
	logic                  alu_valid;
	logic                  lsu_busy;
	logic                  lsu_done;
	logic                  mem_done;
	logic                  mem_inflight_q;
	logic [XLEN-1:0]       alu_result;
	data_lane_u            lsu_rdata;
	logic [2:0]            lsu_addr_lo;
	load_code_e            ld_code_q;
	logic [REG_ADDR_W-1:0] rd_addr_q;
	logic                  reg_wr_en_q;

	// ------------------------------
	// hold and acceptance
	// ------------------------------
	assign freeze    = (hold_code_i >= HOLD_EX);
	assign ready_o   = !mem_inflight_q && !freeze;
	assign accept    = valid_i && ready_o;
	assign alu_valid = accept && !mem_req.valid;

	// done now, or finished earlier while frozen.
	assign mem_done = lsu_done || (mem_inflight_q && !lsu_busy);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			mem_inflight_q <= 1'b0;
		end else if (accept && mem_req.valid) begin
			mem_inflight_q <= 1'b1;
		end else if (mem_done && !freeze) begin
			mem_inflight_q <= 1'b0; // result taken by EX/MEM.
		end
	end

	// write-back info of the memory instruction.
	always_ff @(posedge clk) begin
		if (accept && mem_req.valid) begin
			ld_code_q   <= load_code_i;
			rd_addr_q   <= rd_addr_i;
			reg_wr_en_q <= reg_wr_en_i;
		end
	end

	// ------------------------------
	// blocks
	// ------------------------------
	ex_alu i_ex_alu (
		.alu_op_i     (alu_op_i),
		.word_op_i    (word_op_i),
		.op_a_i       (op_a_i),
		.op_b_i       (op_b_i),
		.rs2_data_i   (rs2_data_i),
		.load_code_i  (load_code_i),
		.store_code_i (store_code_i),
		.result_o     (alu_result),
		.req          (mem_req)
	);

	lsu_apb i_lsu_apb (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.start_i   (accept),
		.req       (mem_req),
		.psel_o    (psel_o),
		.penable_o (penable_o),
		.pwrite_o  (pwrite_o),
		.paddr_o   (paddr_o),
		.pwdata_o  (pwdata_o),
		.pstrb_o   (pstrb_o),
		.prdata_i  (prdata_i),
		.pready_i  (pready_i),
		.busy_o    (lsu_busy),
		.done_o    (lsu_done),
		.rdata_o   (lsu_rdata),
		.addr_lo_o (lsu_addr_lo)
	);

	ex_mem_reg i_ex_mem_reg (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.freeze_i      (freeze),
		.alu_valid_i   (alu_valid),
		.alu_result_i  (alu_result),
		.mem_done_i    (mem_done),
		.mem_rdata_i   (lsu_rdata),
		.addr_lo_i     (lsu_addr_lo),
		.load_code_i   (ld_code_q),
		.rd_addr_i     (mem_inflight_q ? rd_addr_q : rd_addr_i),
		.reg_wr_en_i   (mem_inflight_q ? reg_wr_en_q : reg_wr_en_i),
		.wb_valid_o    (wb_valid_o),
		.reg_wr_en_o   (reg_wr_en_o),
		.addr_reg_wr_o (addr_reg_wr_o),
		.data_reg_wr_o (data_reg_wr_o)
	);

	// no new instruction while a bus transfer runs.
	a_busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
		psel_o |-> !ready_o)
		else $error("ex_stage: ready during APB transfer.");

endmodule

/* lsu_apb.sv */
/*
 * APB load-store unit.
 * Runs one SETUP/ACCESS transfer per memory request and keeps
 * the read data until the next request.
 */
`timescale 1ns/1ps

module lsu_apb
	import pipe_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               start_i,
	mem_req_if.rcv             req,
	output logic               psel_o,
	output logic               penable_o,
	output logic               pwrite_o,
	output logic [PADDR_W-1:0] paddr_o,
	output logic [PDATA_W-1:0] pwdata_o,
	output logic [PSTRB_W-1:0] pstrb_o,
	input  logic [PDATA_W-1:0] prdata_i,
	input  logic               pready_i,
	output logic               busy_o,
	output logic               done_o,
	output data_lane_u         rdata_o,
	output logic [2:0]         addr_lo_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS
	} apb_state_e;

	apb_state_e         state_q;
	logic [PDATA_W-1:0] rdata_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (start_i && req.valid) begin
						state_q <= ST_SETUP;
					end
				end
				ST_SETUP: state_q <= ST_ACCESS; // always one cycle.
				ST_ACCESS: begin
					if (pready_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// request latched for the whole transfer.
	always_ff @(posedge clk) begin
		if (state_q == ST_IDLE && start_i && req.valid) begin
			pwrite_o <= req.write;
			paddr_o  <= req.addr;
			pwdata_o <= req.wdata;
			pstrb_o  <= req.strb;
		end
		if (done_o) begin
			rdata_q <= prdata_i;
		end
	end

	assign psel_o    = (state_q != ST_IDLE);
	assign penable_o = (state_q == ST_ACCESS);
	assign busy_o    = (state_q != ST_IDLE);
	assign done_o    = (state_q == ST_ACCESS) && pready_i;
	assign rdata_o   = done_o ? prdata_i : rdata_q; // live on the completing edge.
	assign addr_lo_o = paddr_o[2:0];

	// ------------------------------
	// protocol checks
	// ------------------------------
	a_enable_after_setup: assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(penable_o) |-> $past(psel_o && !penable_o))
		else $error("lsu_apb: penable without setup phase.");

	a_access_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		psel_o && penable_o |-> $stable(paddr_o) && $stable(pwrite_o))
		else $error("lsu_apb: address changed during access.");

endmodule

/* mem_req_if.sv */
/*
 * Memory request from the ALU to the load-store unit.
 * One aligned load or store, already placed in its byte lanes.
 */
`timescale 1ns/1ps

interface mem_req_if
	import pipe_pkg::*;
();

	logic               valid; // load or store present.
	logic               write;
	logic [PADDR_W-1:0] addr;
	data_lane_u         wdata; // store data, lane aligned.
	logic [PSTRB_W-1:0] strb;

	modport drv (
		output valid, write, addr, wdata, strb
	);

	modport rcv (
		input valid, write, addr, wdata, strb
	);

endinterface

/* pipe_pkg.sv */
/*
 * Pipeline and bus definitions.
 * Hold codes from the pipeline controller, APB widths and the
 * data lane view of one bus word.
 */
package pipe_pkg;

	// ------------------------------
	// pipeline hold
	// ------------------------------
	// a code at or above HOLD_EX freezes the execute stage.
	typedef enum logic [2:0] {
		HOLD_NONE = 3'd0,
		HOLD_IF   = 3'd1,
		HOLD_ID   = 3'd2,
		HOLD_EX   = 3'd3,
		HOLD_WB   = 3'd4
	} hold_code_e;

	// ------------------------------
	// APB bus
	// ------------------------------
	localparam int PADDR_W = 32;
	localparam int PSTRB_W = 8;
	localparam int PDATA_W = PSTRB_W * 8; // one byte per strobe.

	// one bus word, split by lane.
	typedef union packed {
		logic [PDATA_W-1:0]           dw;
		logic [PDATA_W/32-1:0][31:0]  w;
		logic [PDATA_W/16-1:0][15:0]  h;
		logic [PDATA_W/8-1:0][7:0]    b;
	} data_lane_u;

endpackage

/* rv_isa_pkg.sv */
/*
 * RV64I instruction-level definitions.
 * Register widths, ALU operation codes, load and store codes.
 */
package rv_isa_pkg;

	localparam int XLEN       = 64; // register width.
	localparam int REG_ADDR_W = 5;  // x0..x31.

	// ------------------------------
	// ALU operations
	// ------------------------------
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_op_e;

	// ------------------------------
	// memory access codes
	// ------------------------------
	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_LB   = 3'd1,
		LD_LH   = 3'd2,
		LD_LW   = 3'd3,
		LD_LD   = 3'd4,
		LD_LBU  = 3'd5,
		LD_LHU  = 3'd6,
		LD_LWU  = 3'd7
	} load_code_e;

	typedef enum logic [2:0] {
		ST_NONE = 3'd0,
		ST_SB   = 3'd1,
		ST_SH   = 3'd2,
		ST_SW   = 3'd3,
		ST_SD   = 3'd4
	} store_code_e;

endpackage

/* tb_apb_mem.sv */
/*
 * APB slave memory model.
 * 64 double words with byte strobes and 0 to 3 random wait states.
 */
`timescale 1ns/1ps

module tb_apb_mem
	import pipe_pkg::*;
(
	input  logic               clk_i,
	input  logic               psel_i,
	input  logic               penable_i,
	input  logic               pwrite_i,
	input  logic [PADDR_W-1:0] paddr_i,
	input  logic [PDATA_W-1:0] pwdata_i,
	input  logic [PSTRB_W-1:0] pstrb_i,
	output logic [PDATA_W-1:0] prdata_o,
	output logic               pready_o
);

	localparam int WORDS = 64;

	logic [PDATA_W-1:0] mem [WORDS];
	logic [5:0]         idx;
	logic [1:0]         wait_q;
	integer             seed;
	integer             rnd;

	function automatic logic [PDATA_W-1:0] fill_word(logic [PADDR_W-1:0] addr);
		return {addr ^ 32'h5a5a_0000, ~addr};
	endfunction

	initial begin
		seed = 32'h4717e562;
		for (int i = 0; i < WORDS; i++) begin
			mem[i[5:0]] <= fill_word(PADDR_W'(i * 8));
		end
	end

	assign idx      = paddr_i[8:3];
	assign pready_o = psel_i && penable_i && (wait_q == 2'd0);
	assign prdata_o = mem[idx];

	always @(posedge clk_i) begin
		if (psel_i && !penable_i) begin
			rnd = $random(seed); // new wait count per transfer.
			wait_q <= rnd[1:0];
		end else if (psel_i && penable_i && (wait_q != 2'd0)) begin
			wait_q <= wait_q - 2'd1;
		end
		if (psel_i && penable_i && pready_o && pwrite_i) begin
			for (int b = 0; b < PSTRB_W; b++) begin
				if (pstrb_i[b]) begin
					mem[idx][8*b +: 8] <= pwdata_i[8*b +: 8];
				end
			end
		end
	end

endmodule

/* tb_clk_gen.sv */
/*
 * Testbench clock and reset.
 * 20 ns clock, active-low reset held for 16 cycles.
 */
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int HALF_PERIOD = 10; // ns.
	localparam int RST_CYCLES  = 16;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1; // released away from the sampling edge.
	end

endmodule

/* tb_ex_stage.sv */
/*
 * Testbench for the execute stage.
 * Table of instructions with expected write-back values from a
 * behavioral model, APB memory with random wait states.
 */
`timescale 1ns/1ps

module tb_ex_stage
	import rv_isa_pkg::*;
	import pipe_pkg::*;
();

	localparam int WAIT_LIMIT  = 40; // cycles per wait.
	localparam int HOLD_CYCLES = 4;
	localparam int MEM_BYTES   = 512;
	localparam logic [XLEN-1:0] BASE_B = 64'h40;
	localparam logic [XLEN-1:0] BASE_H = 64'h48;
	localparam logic [XLEN-1:0] BASE_W = 64'h50;
	localparam logic [XLEN-1:0] BASE_D = 64'h58;

	typedef struct packed {
		alu_op_e               op;
		logic                  word;
		logic [XLEN-1:0]       a;
		logic [XLEN-1:0]       b;
		logic [XLEN-1:0]       rs2;
		load_code_e            ld;
		store_code_e           st;
		logic [REG_ADDR_W-1:0] rd;
		logic                  wr_en;
		hold_code_e            hold;
		logic [XLEN-1:0]       exp_data;
		logic                  exp_wr_en;
	} entry_t;

	logic                  clk;
	logic                  rst_n;
	hold_code_e            hold_code_i;
	logic                  valid_i;
	logic                  ready_o;
	alu_op_e               alu_op_i;
	logic                  word_op_i;
	logic [XLEN-1:0]       op_a_i;
	logic [XLEN-1:0]       op_b_i;
	logic [XLEN-1:0]       rs2_data_i;
	load_code_e            load_code_i;
	store_code_e           store_code_i;
	logic [REG_ADDR_W-1:0] rd_addr_i;
	logic                  reg_wr_en_i;
	logic                  wb_valid_o;
	logic                  reg_wr_en_o;
	logic [REG_ADDR_W-1:0] addr_reg_wr_o;
	logic [XLEN-1:0]       data_reg_wr_o;
	logic                  psel_o;
	logic                  penable_o;
	logic                  pwrite_o;
	logic [PADDR_W-1:0]    paddr_o;
	logic [PDATA_W-1:0]    pwdata_o;
	logic [PSTRB_W-1:0]    pstrb_o;
	logic [PDATA_W-1:0]    prdata_i;
	logic                  pready_i;

	entry_t     tbl_q[$];
	string      name_q[$];
	logic [7:0] shadow [MEM_BYTES]; // expected memory contents.
	int         n_tests;
	int         n_errors;
	bit         timed_out;

	tb_clk_gen i_clk_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	tb_apb_mem i_mem (
		.clk_i     (clk),
		.psel_i    (psel_o),
		.penable_i (penable_o),
		.pwrite_i  (pwrite_o),
		.paddr_i   (paddr_o),
		.pwdata_i  (pwdata_o),
		.pstrb_i   (pstrb_o),
		.prdata_o  (prdata_i),
		.pready_o  (pready_i)
	);

	ex_stage i_dut (
		.clk           (clk),
		.rst_n_i       (rst_n),
		.hold_code_i   (hold_code_i),
		.valid_i       (valid_i),
		.ready_o       (ready_o),
		.alu_op_i      (alu_op_i),
		.word_op_i     (word_op_i),
		.op_a_i        (op_a_i),
		.op_b_i        (op_b_i),
		.rs2_data_i    (rs2_data_i),
		.load_code_i   (load_code_i),
		.store_code_i  (store_code_i),
		.rd_addr_i     (rd_addr_i),
		.reg_wr_en_i   (reg_wr_en_i),
		.wb_valid_o    (wb_valid_o),
		.reg_wr_en_o   (reg_wr_en_o),
		.addr_reg_wr_o (addr_reg_wr_o),
		.data_reg_wr_o (data_reg_wr_o),
		.psel_o        (psel_o),
		.penable_o     (penable_o),
		.pwrite_o      (pwrite_o),
		.paddr_o       (paddr_o),
		.pwdata_o      (pwdata_o),
		.pstrb_o       (pstrb_o),
		.prdata_i      (prdata_i),
		.pready_i      (pready_i)
	);

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic logic [XLEN-1:0] sext32(logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	function automatic logic [XLEN-1:0] alu_ref(alu_op_e op, logic word,
			logic [XLEN-1:0] a, logic [XLEN-1:0] b);
		logic [XLEN-1:0]   ua;
		logic [XLEN-1:0]   ub;
		logic [XLEN-1:0]   sa;
		logic [XLEN-1:0]   sb;
		logic [XLEN-1:0]   r;
		logic [2*XLEN-1:0] wide;
		logic [5:0]        sh;
		ua   = word ? {32'd0, a[31:0]} : a; // zero view.
		ub   = word ? {32'd0, b[31:0]} : b;
		sa   = word ? sext32(a[31:0]) : a;  // signed view.
		sb   = word ? sext32(b[31:0]) : b;
		sh   = word ? {1'b0, b[4:0]} : b[5:0];
		wide = {{XLEN{sa[XLEN-1]}}, sa} >> sh;
		case (op)
			ALU_ADD:  r = ua + ub;
			ALU_SUB:  r = ua - ub;
			ALU_SLL:  r = ua << sh;
			ALU_SLT:  r = (sa[63] != sb[63]) ? {63'd0, sa[63]} : {63'd0, sa < sb};
			ALU_SLTU: r = {63'd0, ua < ub};
			ALU_XOR:  r = ua ^ ub;
			ALU_SRL:  r = ua >> sh;
			ALU_SRA:  r = wide[XLEN-1:0];
			ALU_OR:   r = ua | ub;
			ALU_AND:  r = ua & ub;
			default:  r = '0;
		endcase
		return word ? sext32(r[31:0]) : r;
	endfunction

	function automatic int access_bytes(load_code_e ld, store_code_e st);
		if (st == ST_SB || ld == LD_LB || ld == LD_LBU) return 1;
		if (st == ST_SH || ld == LD_LH || ld == LD_LHU) return 2;
		if (st == ST_SW || ld == LD_LW || ld == LD_LWU) return 4;
		return 8;
	endfunction

	task automatic store_ref(logic [PADDR_W-1:0] addr, store_code_e st,
			logic [XLEN-1:0] data);
		int         n;
		logic [8:0] idx;
		n = access_bytes(LD_NONE, st);
		for (int k = 0; k < n; k++) begin
			idx         = addr[8:0] + 9'(k);
			shadow[idx] = 8'(data >> (8 * k));
		end
	endtask

	function automatic logic [XLEN-1:0] load_ref(logic [PADDR_W-1:0] addr, load_code_e ld);
		logic [XLEN-1:0] v;
		logic [8:0]      idx;
		int              n;
		n = access_bytes(ld, ST_NONE);
		v = '0;
		for (int k = n - 1; k >= 0; k--) begin
			idx = addr[8:0] + 9'(k);
			v   = (v << 8) | {56'd0, shadow[idx]};
		end
		if ((ld inside {LD_LB, LD_LH, LD_LW}) && (((v >> (8 * n - 1)) & 64'd1) != 64'd0)) begin
			v = v | (~64'd0 << (8 * n)); // sign fill.
		end
		return v;
	endfunction

	// ------------------------------
	// table
	// ------------------------------
	task automatic add_entry(string name, alu_op_e op, logic word, logic [XLEN-1:0] a,
			logic [XLEN-1:0] b, logic [XLEN-1:0] rs2, load_code_e ld, store_code_e st,
			logic wr_en, hold_code_e hold);
		entry_t          e;
		logic [XLEN-1:0] addr;
		e.op    = op;
		e.word  = word;
		e.a     = a;
		e.b     = b;
		e.rs2   = rs2;
		e.ld    = ld;
		e.st    = st;
		e.rd    = 5'(tbl_q.size() % 31 + 1);
		e.wr_en = wr_en;
		e.hold  = hold;
		addr    = a + b;
		if (st != ST_NONE) begin
			store_ref(addr[PADDR_W-1:0], st, rs2);
			e.exp_data  = '0;
			e.exp_wr_en = 1'b0; // stores never write back.
		end else if (ld != LD_NONE) begin
			e.exp_data  = load_ref(addr[PADDR_W-1:0], ld);
			e.exp_wr_en = wr_en;
		end else begin
			e.exp_data  = alu_ref(op, word, a, b);
			e.exp_wr_en = wr_en;
		end
		tbl_q.push_back(e);
		name_q.push_back(name);
	endtask

	task automatic add_alu(string name, alu_op_e op, logic word, logic [XLEN-1:0] a,
			logic [XLEN-1:0] b, hold_code_e hold);
		add_entry(name, op, word, a, b, '0, LD_NONE, ST_NONE, 1'b1, hold);
	endtask

	task automatic add_mem(string name, load_code_e ld, store_code_e st,
			logic [XLEN-1:0] base, logic [XLEN-1:0] off, logic [XLEN-1:0] rs2);
		add_entry(name, ALU_ADD, 1'b0, base, off, rs2, ld, st, 1'b1, HOLD_NONE);
	endtask

	function automatic logic [XLEN-1:0] store_pattern(int off);
		return 64'hf1e2_d3c4_b5a6_9788 + 64'h1111_1111_1111_1111 * XLEN'(off);
	endfunction

	task automatic build_table();
		load_code_e lc;
		string      nm;
		add_alu("add", ALU_ADD, 1'b0, 64'hfedc_ba98_7654_3210, 64'h0123_4567_89ab_cdef, HOLD_NONE);
		add_alu("sub", ALU_SUB, 1'b0, 64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210, HOLD_NONE);
		add_alu("sll", ALU_SLL, 1'b0, 64'hfedc_ba98_7654_3210, 64'h44, HOLD_NONE);
		add_alu("slt_neg", ALU_SLT, 1'b0, 64'hffff_ffff_ffff_fffb, 64'd3, HOLD_NONE);
		add_alu("sltu_neg", ALU_SLTU, 1'b0, 64'hffff_ffff_ffff_fffb, 64'd3, HOLD_NONE);
		add_alu("slt_same", ALU_SLT, 1'b0, 64'hffff_ffff_ffff_fff8, 64'hffff_ffff_ffff_fffb,
			HOLD_NONE);
		add_alu("xor", ALU_XOR, 1'b0, 64'hfedc_ba98_7654_3210, 64'h0123_4567_89ab_cdef, HOLD_NONE);
		add_alu("srl", ALU_SRL, 1'b0, 64'hfedc_ba98_7654_3210, 64'hc4, HOLD_NONE);
		add_alu("sra", ALU_SRA, 1'b0, 64'hfedc_ba98_7654_3210, 64'd8, HOLD_NONE);
		add_alu("or", ALU_OR, 1'b0, 64'hf0f0_0000_1234_0000, 64'h0f00_ff00_0000_5678, HOLD_NONE);
		add_alu("and", ALU_AND, 1'b0, 64'hfedc_ba98_7654_3210, 64'h00ff_00ff_f0f0_0f0f, HOLD_NONE);
		add_entry("add_no_wr", ALU_ADD, 1'b0, 64'd5, 64'd7, '0, LD_NONE, ST_NONE, 1'b0, HOLD_NONE);
		// word forms.
		add_alu("addw", ALU_ADD, 1'b1, 64'h1234_5678_7fff_ffff, 64'd1, HOLD_NONE);
		add_alu("subw", ALU_SUB, 1'b1, 64'h0, 64'd1, HOLD_NONE);
		add_alu("sllw", ALU_SLL, 1'b1, 64'd1, 64'h3f, HOLD_NONE);
		add_alu("srlw", ALU_SRL, 1'b1, 64'hffff_ffff_8000_0000, 64'h24, HOLD_NONE);
		add_alu("sraw", ALU_SRA, 1'b1, 64'hffff_ffff_8000_0000, 64'h24, HOLD_NONE);
		add_alu("sltw", ALU_SLT, 1'b1, 64'h0000_0001_8000_0000, 64'd0, HOLD_NONE);
		// hold codes.
		add_alu("hold_ex", ALU_ADD, 1'b0, 64'h1111, 64'h2222, HOLD_EX);
		add_alu("hold_wb", ALU_XOR, 1'b0, 64'h5555_aaaa, 64'hffff_0000, HOLD_WB);
		add_alu("hold_id", ALU_SUB, 1'b0, 64'd100, 64'd1, HOLD_ID);
		add_alu("hold_if", ALU_AND, 1'b0, 64'hff0f, 64'h0ff0, HOLD_IF);
		// each store read back at the same place.
		for (int off = 0; off < 8; off++) begin
			if (off % 2 == 0) begin
				lc = LD_LB;
				nm = "lb";
			end else begin
				lc = LD_LBU;
				nm = "lbu";
			end
			add_mem($sformatf("sb_off%0d", off), LD_NONE, ST_SB, BASE_B, XLEN'(off),
				store_pattern(off));
			add_mem($sformatf("%s_off%0d", nm, off), lc, ST_NONE, BASE_B, XLEN'(off), '0);
		end
		for (int off = 0; off < 8; off += 2) begin
			if (off % 4 == 0) begin
				lc = LD_LH;
				nm = "lh";
			end else begin
				lc = LD_LHU;
				nm = "lhu";
			end
			add_mem($sformatf("sh_off%0d", off), LD_NONE, ST_SH, BASE_H, XLEN'(off),
				store_pattern(off));
			add_mem($sformatf("%s_off%0d", nm, off), lc, ST_NONE, BASE_H, XLEN'(off), '0);
		end
		add_mem("sw_off0", LD_NONE, ST_SW, BASE_W, 64'd0, store_pattern(1));
		add_mem("lw_off0", LD_LW, ST_NONE, BASE_W, 64'd0, '0);
		add_mem("sw_off4", LD_NONE, ST_SW, BASE_W, 64'd4, 64'h0000_0000_8654_3210);
		add_mem("lwu_off4", LD_LWU, ST_NONE, BASE_W, 64'd4, '0);
		add_mem("sd_off0", LD_NONE, ST_SD, BASE_D, 64'd0, 64'h8899_aabb_ccdd_eeff);
		add_mem("ld_off0", LD_LD, ST_NONE, BASE_D, 64'd0, '0);
		// whole words after the narrow stores.
		add_mem("ld_bytes", LD_LD, ST_NONE, BASE_B, 64'd0, '0);
		add_mem("ld_halves", LD_LD, ST_NONE, BASE_H, 64'd0, '0);
		add_mem("ld_words", LD_LD, ST_NONE, BASE_W, 64'd0, '0);
		add_mem("lb_dword3", LD_LB, ST_NONE, BASE_D, 64'd3, '0);
		add_mem("lhu_neg_off", LD_LHU, ST_NONE, BASE_H + 64'd8, 64'hffff_ffff_ffff_fffa, '0);
		add_entry("hold_ld", ALU_ADD, 1'b0, BASE_D, 64'd0, '0, LD_LD, ST_NONE, 1'b1, HOLD_EX);
	endtask

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic check_data(string nm, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
		if (act !== exp) begin
			n_errors++;
			$display("error %s: data expected %h actual %h", nm, exp, act);
		end
	endtask

	task automatic check_wr_en(string nm, bit exp, logic act);
		if (act !== exp) begin
			n_errors++;
			$display("error %s: reg_wr_en expected %b actual %b", nm, exp, act);
		end
	endtask

	task automatic check_addr(string nm, logic [REG_ADDR_W-1:0] exp,
			logic [REG_ADDR_W-1:0] act);
		if (act !== exp) begin
			n_errors++;
			$display("error %s: rd address expected %0d actual %0d", nm, exp, act);
		end
	endtask

	task automatic check_flag(string nm, string sig, bit exp, logic act);
		if (act !== exp) begin
			n_errors++;
			$display("error %s: %s expected %b actual %b", nm, sig, exp, act);
		end
	endtask

	// ------------------------------
	// sequencing
	// ------------------------------
	task automatic wait_reset();
		int waited;
		waited = 0;
		while (!rst_n) begin
			if (waited == WAIT_LIMIT) begin
				$display("timeout: reset never released");
				timed_out = 1'b1;
				return;
			end
			@(negedge clk);
			waited++;
		end
		check_flag("reset", "psel_o", 1'b0, psel_o);
		check_flag("reset", "penable_o", 1'b0, penable_o);
		check_flag("reset", "wb_valid_o", 1'b0, wb_valid_o);
		check_flag("reset", "reg_wr_en_o", 1'b0, reg_wr_en_o);
		check_flag("reset", "ready_o", 1'b1, ready_o);
	endtask

	task automatic run_entry(int i);
		entry_t                e;
		string                 nm;
		int                    waited;
		int                    errs_before;
		bit                    is_mem;
		logic                  snap_valid;
		logic                  snap_wr;
		logic [REG_ADDR_W-1:0] snap_addr;
		logic [XLEN-1:0]       snap_data;
		e           = tbl_q[i];
		nm          = name_q[i];
		errs_before = n_errors;
		is_mem      = (e.ld != LD_NONE) || (e.st != ST_NONE);
		@(negedge clk);
		hold_code_i  = e.hold;
		valid_i      = 1'b1;
		alu_op_i     = e.op;
		word_op_i    = e.word;
		op_a_i       = e.a;
		op_b_i       = e.b;
		rs2_data_i   = e.rs2;
		load_code_i  = e.ld;
		store_code_i = e.st;
		rd_addr_i    = e.rd;
		reg_wr_en_i  = e.wr_en;
		if (e.hold >= HOLD_EX) begin
			snap_valid = wb_valid_o;
			snap_wr    = reg_wr_en_o;
			snap_addr  = addr_reg_wr_o;
			snap_data  = data_reg_wr_o;
			repeat (HOLD_CYCLES) begin
				@(negedge clk);
				check_flag(nm, "ready_o", 1'b0, ready_o);
				check_flag(nm, "psel_o", 1'b0, psel_o);
				check_flag(nm, "wb_valid_o", snap_valid, wb_valid_o);
				check_wr_en(nm, snap_wr, reg_wr_en_o);
				check_addr(nm, snap_addr, addr_reg_wr_o);
				check_data(nm, snap_data, data_reg_wr_o);
			end
			hold_code_i = HOLD_NONE; // taken on the next rising edge.
		end else begin
			waited = 0;
			while (!ready_o) begin
				if (waited == WAIT_LIMIT) begin
					$display("timeout: %s was never accepted", nm);
					timed_out = 1'b1;
					return;
				end
				@(negedge clk);
				waited++;
			end
		end
		@(negedge clk); // accepted on the rising edge just passed.
		valid_i = 1'b0;
		if (is_mem) begin
			waited = 0;
			while (!wb_valid_o) begin
				check_flag(nm, "ready_o", 1'b0, ready_o);
				check_flag(nm, "psel_o", 1'b1, psel_o);
				if (waited == WAIT_LIMIT) begin
					$display("timeout: %s got no write-back from the bus", nm);
					timed_out = 1'b1;
					return;
				end
				@(negedge clk);
				waited++;
			end
			check_flag(nm, "ready_o", 1'b1, ready_o);
		end else begin
			check_flag(nm, "wb_valid_o", 1'b1, wb_valid_o); // one cycle latency.
		end
		check_wr_en(nm, e.exp_wr_en, reg_wr_en_o);
		check_addr(nm, e.rd, addr_reg_wr_o);
		if (e.st == ST_NONE) begin
			check_data(nm, e.exp_data, data_reg_wr_o);
		end
		n_tests++;
		if (n_errors == errs_before) begin
			$display("%-14s ok", nm);
		end else begin
			$display("%-14s failed", nm);
		end
	endtask

	initial begin
		hold_code_i  = HOLD_NONE;
		valid_i      = 1'b0;
		alu_op_i     = ALU_ADD;
		word_op_i    = 1'b0;
		op_a_i       = '0;
		op_b_i       = '0;
		rs2_data_i   = '0;
		load_code_i  = LD_NONE;
		store_code_i = ST_NONE;
		rd_addr_i    = '0;
		reg_wr_en_i  = 1'b0;
		n_tests      = 0;
		n_errors     = 0;
		timed_out    = 1'b0;
		build_table();
		wait_reset();
		for (int i = 0; i < tbl_q.size() && !timed_out; i++) begin
			run_entry(i);
		end
		$display("tests run %0d, errors %0d", n_tests, n_errors);
		if (timed_out || n_errors != 0) begin
			$display("Checks failed");
		end else begin
			$display("All checks passed");
		end
		$finish;
	end

endmodule
